//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -Iinclude
TOP      := calc_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := run.log
FAIL_MSG := Verification failed
PASS_MSG := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/calc_tb.sv
`include "calc_defs.svh"

module calc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BTN_ADD = 0;
	localparam int BTN_MINUS = 1;
	localparam int BTN_EQUAL = 2;
	localparam int WAIT_LIMIT = 12; // poll limit in cycles

	logic clk;
	logic rst_n;
	logic add; // buttons idle high
	logic minus;
	logic equal;
	logic digit_valid;
	calc_pkg::digit_t digit;
	calc_pkg::display_t disp;
	calc_pkg::calc_state_e state;

	// reference model
	calc_pkg::operand_t model_left;
	calc_pkg::operand_t model_right;
	calc_pkg::result_t model_answer;
	calc_pkg::calc_state_e model_state;

	logic [31:0] lfsr_state;
	int error_count;
	int check_count;
	int test_count;

	calc_top calc_top_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.add (add),
		.minus (minus),
		.equal (equal),
		.digit_valid (digit_valid),
		.digit (digit),
		.disp (disp),
		.state (state)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	//////////////////////////////
	// random digits
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function calc_pkg::digit_t random_digit();
		logic [3:0] bits;
		bits = '0;
		for (int i = 0; i < 4; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			bits = {bits[2:0], lfsr_state[0]};
		end
		return calc_pkg::digit_t'(bits % 4'd10);
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	function void model_digit(input calc_pkg::digit_t code);
		if (code > 4'd9)
			return; // scanner junk
		case (model_state)
			calc_pkg::ST_LEFT:
				model_left = calc_pkg::operand_t'(int'(model_left) * 10 + int'(code));
			calc_pkg::ST_RIGHT_ADD, calc_pkg::ST_RIGHT_MINUS:
				model_right = calc_pkg::operand_t'(int'(model_right) * 10 + int'(code));
			default: ; // frozen
		endcase
	endfunction

	function void model_button(input int btn);
		case (model_state)
			calc_pkg::ST_LEFT:
			begin
				if (btn == BTN_ADD)
					model_state = calc_pkg::ST_RIGHT_ADD;
				else if (btn == BTN_MINUS)
					model_state = calc_pkg::ST_RIGHT_MINUS;
			end
			calc_pkg::ST_RIGHT_ADD:
			begin
				if (btn == BTN_MINUS)
					model_state = calc_pkg::ST_RIGHT_MINUS;
				else if (btn == BTN_EQUAL)
				begin
					model_state = calc_pkg::ST_EQUAL_ADD;
					model_answer = calc_pkg::result_t'(int'(model_left) + int'(model_right));
				end
			end
			calc_pkg::ST_RIGHT_MINUS:
			begin
				if (btn == BTN_ADD)
					model_state = calc_pkg::ST_RIGHT_ADD;
				else if (btn == BTN_EQUAL)
				begin
					model_state = calc_pkg::ST_EQUAL_MINUS;
					model_answer = calc_pkg::result_t'(int'(model_left) - int'(model_right));
				end
			end
			default: ; // answer held until reset
		endcase
	endfunction

	function calc_pkg::display_t expected_display();
		calc_pkg::display_t d;
		case (model_state)
			calc_pkg::ST_EQUAL_ADD, calc_pkg::ST_EQUAL_MINUS:
				d = '{value: model_answer, is_answer: 1'b1};
			calc_pkg::ST_RIGHT_ADD, calc_pkg::ST_RIGHT_MINUS:
				d = '{value: calc_pkg::result_t'(int'(model_right)), is_answer: 1'b0};
			default:
				d = '{value: calc_pkg::result_t'(int'(model_left)), is_answer: 1'b0};
		endcase
		return d;
	endfunction

	//////////////////////////////
	// stimulus and checks
	//////////////////////////////

	task apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		add = 1'b1;
		minus = 1'b1;
		equal = 1'b1;
		digit_valid = 1'b0;
		digit = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		model_left = '0;
		model_right = '0;
		model_answer = '0;
		model_state = calc_pkg::ST_LEFT;
	endtask

	task key_digit(input calc_pkg::digit_t code);
		@(negedge clk);
		digit_valid = 1'b1;
		digit = code;
		@(negedge clk);
		digit_valid = 1'b0; // one-cycle strobe
		model_digit(code);
	endtask

	task press_button(input int btn);
		@(negedge clk);
		case (btn)
			BTN_ADD: add = 1'b0;
			BTN_MINUS: minus = 1'b0;
			default: equal = 1'b0;
		endcase
		repeat (5) @(negedge clk); // held low 5 cycles
		add = 1'b1;
		minus = 1'b1;
		equal = 1'b1;
		repeat (`CALC_SYNC_STAGES + 1) @(negedge clk); // release reaches the edge detector
		model_button(btn);
	endtask

	task idle_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk);
	endtask

	task check_display(input calc_pkg::display_t expected, input calc_pkg::display_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Error at %0t: disp (value/is_answer) expected %0d/%0b, actual %0d/%0b",
				$time, expected.value, expected.is_answer, actual.value, actual.is_answer);
		end
	endtask

	task check_state(input calc_pkg::calc_state_e expected, input calc_pkg::calc_state_e actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Error at %0t: state expected %s, actual %s",
				$time, expected.name(), actual.name());
		end
	endtask

	// poll until disp and state match the model
	task wait_and_check();
		calc_pkg::display_t exp_disp;
		int cycles;
		exp_disp = expected_display();
		cycles = 0;
		while ((disp !== exp_disp || state !== model_state) && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (disp !== exp_disp || state !== model_state)
			$display("Timeout at %0t: disp and state did not settle within %0d cycles",
				$time, WAIT_LIMIT);
		check_display(exp_disp, disp);
		check_state(model_state, state);
	endtask

	task key_number(input int unsigned n);
		int unsigned div;
		div = 1;
		while (div * 10 <= n)
			div = div * 10;
		while (div > 0)
		begin
			key_digit(calc_pkg::digit_t'((n / div) % 10)); // most significant first
			wait_and_check();
			div = div / 10;
		end
	endtask

	task report_test(input string name, input int start_errors);
		test_count++;
		if (error_count == start_errors)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: FAILED with %0d errors", test_count, name,
				error_count - start_errors);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task test_reset_and_entry();
		int start;
		start = error_count;
		apply_reset();
		wait_and_check(); // zero in ST_LEFT
		key_digit(4'd9); // 9xxxxx is past 65535
		wait_and_check();
		for (int i = 0; i < 5; i++)
		begin
			key_digit(random_digit());
			wait_and_check();
		end
		report_test("reset and left entry", start);
	endtask

	task test_addition();
		int start;
		start = error_count;
		apply_reset();
		key_number(40000);
		press_button(BTN_ADD);
		wait_and_check();
		key_number(30000);
		press_button(BTN_EQUAL);
		wait_and_check(); // 70000 wraps into the sign bit
		report_test("addition", start);
	endtask

	task test_negative_difference();
		int start;
		start = error_count;
		apply_reset();
		key_number(123);
		press_button(BTN_MINUS);
		wait_and_check();
		key_number(4567);
		press_button(BTN_EQUAL);
		wait_and_check(); // -4444
		report_test("negative difference", start);
	endtask

	task test_switch_operation();
		int start;
		start = error_count;
		apply_reset();
		key_number(900);
		press_button(BTN_ADD);
		wait_and_check();
		key_number(25); // kept across the switch
		press_button(BTN_MINUS);
		wait_and_check();
		key_digit(4'd0);
		wait_and_check();
		press_button(BTN_EQUAL);
		wait_and_check(); // 900 minus 250
		report_test("switch add to minus", start);
	endtask

	task test_ignored_inputs();
		int start;
		start = error_count;
		apply_reset();
		key_digit(4'd12);
		key_digit(4'd15);
		key_digit(4'd10);
		idle_cycles(4);
		wait_and_check(); // still zero
		press_button(BTN_EQUAL); // no op in ST_LEFT
		wait_and_check();
		key_number(7);
		press_button(BTN_MINUS);
		wait_and_check();
		key_number(3);
		press_button(BTN_EQUAL);
		wait_and_check();
		key_digit(4'd5);
		idle_cycles(4);
		wait_and_check(); // answer frozen
		press_button(BTN_ADD);
		wait_and_check();
		press_button(BTN_MINUS);
		wait_and_check();
		press_button(BTN_EQUAL);
		wait_and_check();
		report_test("ignored inputs", start);
	endtask

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		rst_n = 1'b0;
		add = 1'b1;
		minus = 1'b1;
		equal = 1'b1;
		digit_valid = 1'b0;
		digit = '0;
		model_left = '0;
		model_right = '0;
		model_answer = '0;
		model_state = calc_pkg::ST_LEFT;
		lfsr_state = 32'hac6120f1;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		test_reset_and_entry();
		test_addition();
		test_negative_difference();
		test_switch_operation();
		test_ignored_inputs();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
logic/calc_pkg.sv
logic/calc_keys.sv
logic/calc_fsm.sv
logic/operand_entry.sv
logic/calc_result.sv
logic/calc_top.sv
dv/calc_tb.sv

//--- include/calc_defs.svh
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

//////////////////////////////
// calculator widths
//////////////////////////////

// operand word, wraps at this width
`define CALC_OPERAND_W 16

// keypad scanner code width
`define CALC_DIGIT_W 4

//////////////////////////////
// button synchronizer
//////////////////////////////

// flops per button, must be 2 or more
`define CALC_SYNC_STAGES 2

`endif

//--- logic/calc_fsm.sv
module calc_fsm
(
	input logic clk,
	input logic rst_n,
	input calc_pkg::key_evt_t evt,
	output calc_pkg::entry_ctrl_t ctrl,
	output calc_pkg::calc_state_e state // exported for observation
);

	calc_pkg::calc_state_e next_state;

	//////////////////////////////
	// state register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= calc_pkg::ST_LEFT;
		else
			state <= next_state;
	end

	//////////////////////////////
	// next state
	//////////////////////////////

	// pulses instead of button levels, priority add > minus > equal
	always_comb
	begin
		next_state = state; // hold unless an event moves us
		case (state)
			calc_pkg::ST_LEFT:
			begin
				if (evt.add)
					next_state = calc_pkg::ST_RIGHT_ADD;
				else if (evt.minus)
					next_state = calc_pkg::ST_RIGHT_MINUS;
				// equal here does nothing
			end
			calc_pkg::ST_RIGHT_ADD:
			begin
				if (evt.minus)
					next_state = calc_pkg::ST_RIGHT_MINUS; // switch op
				else if (evt.equal)
					next_state = calc_pkg::ST_EQUAL_ADD;
			end
			calc_pkg::ST_RIGHT_MINUS:
			begin
				if (evt.add)
					next_state = calc_pkg::ST_RIGHT_ADD; // switch op
				else if (evt.equal)
					next_state = calc_pkg::ST_EQUAL_MINUS;
			end
			calc_pkg::ST_EQUAL_ADD,
			calc_pkg::ST_EQUAL_MINUS:
				next_state = state; // frozen until rst_n
			default:
				next_state = calc_pkg::ST_LEFT; // illegal codes recover
		endcase
	end

	//////////////////////////////
	// enables, state only
	//////////////////////////////

	always_comb
	begin
		ctrl = '0;
		case (state)
			calc_pkg::ST_LEFT: ctrl.left_en = 1'b1;
			calc_pkg::ST_RIGHT_ADD: ctrl.right_en = 1'b1;
			calc_pkg::ST_RIGHT_MINUS:
			begin
				ctrl.right_en = 1'b1;
				ctrl.subtract = 1'b1;
			end
			calc_pkg::ST_EQUAL_ADD: ctrl.ans_en = 1'b1;
			calc_pkg::ST_EQUAL_MINUS:
			begin
				ctrl.ans_en = 1'b1;
				ctrl.subtract = 1'b1;
			end
			default: ctrl.left_en = 1'b1; // same as ST_LEFT
		endcase
	end

endmodule

//--- logic/calc_keys.sv
`include "calc_defs.svh"

module calc_keys
(
	input logic clk,
	input logic rst_n,
	input logic add, // active low, async
	input logic minus, // active low, async
	input logic equal, // active low, async
	input logic digit_valid, // sync strobe from keypad scanner
	input calc_pkg::digit_t digit,
	output calc_pkg::key_evt_t evt
);

	localparam int NUM_BTN = 3;
	localparam int SYNC_TOP = `CALC_SYNC_STAGES - 1;

	logic [NUM_BTN-1:0] btn_raw; // {add, minus, equal}
	logic [NUM_BTN-1:0][SYNC_TOP:0] btn_sync; // per button shift chain
	logic [NUM_BTN-1:0] btn_last; // synced level one cycle back
	logic [NUM_BTN-1:0] btn_fall; // high to low seen this cycle

	assign btn_raw = {add, minus, equal};

	//////////////////////////////
	// button synchronizers
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			btn_sync <= '1; // released is high
			btn_last <= '1;
		end
		else
		begin
			for (int i = 0; i < NUM_BTN; i++)
			begin
				btn_sync[i] <= {btn_sync[i][SYNC_TOP-1:0], btn_raw[i]};
				btn_last[i] <= btn_sync[i][SYNC_TOP];
			end
		end
	end

	// press = last synced level high, current low
	always_comb
	begin
		for (int i = 0; i < NUM_BTN; i++)
			btn_fall[i] = btn_last[i] & ~btn_sync[i][SYNC_TOP];
	end

	//////////////////////////////
	// event register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			evt <= '0; // no pulses out of reset
		else
		begin
			evt.add <= btn_fall[2];
			evt.minus <= btn_fall[1];
			evt.equal <= btn_fall[0];
			evt.digit_valid <= digit_valid && (digit <= calc_pkg::digit_t'(9)); // drop a..f
			evt.digit <= digit;
		end
	end

endmodule

//--- logic/calc_pkg.sv
package calc_pkg;

	`include "calc_defs.svh"

	//////////////////////////////
	// plain vectors
	//////////////////////////////

	typedef logic [`CALC_OPERAND_W-1:0] operand_t; // unsigned operand word
	typedef logic [`CALC_DIGIT_W-1:0] digit_t; // raw keypad code
	typedef logic signed [`CALC_OPERAND_W:0] result_t; // one extra bit for the sign

	// operation sequencing states
	typedef enum logic [2:0]
	{
		ST_LEFT = 3'd0, // keying left operand
		ST_RIGHT_ADD = 3'd1, // keying right operand for add
		ST_RIGHT_MINUS = 3'd2, // keying right operand for minus
		ST_EQUAL_ADD = 3'd3, // sum frozen
		ST_EQUAL_MINUS = 3'd4 // difference frozen
	} calc_state_e;

	//////////////////////////////
	// grouped signals
	//////////////////////////////

	// one-cycle event pulses out of the key block
	typedef struct packed
	{
		logic digit_valid; // accepted digit code 0..9
		digit_t digit;
		logic add;
		logic minus;
		logic equal;
	} key_evt_t;

	// enables decoded from the state register
	typedef struct packed
	{
		logic left_en;
		logic right_en;
		logic ans_en;
		logic subtract; // set for left minus right
	} entry_ctrl_t;

	// what the display driver gets
	typedef struct packed
	{
		result_t value;
		logic is_answer;
	} display_t;

endpackage

//--- logic/calc_result.sv
module calc_result
(
	input logic clk,
	input logic rst_n,
	input calc_pkg::entry_ctrl_t ctrl,
	input calc_pkg::operand_t left,
	input calc_pkg::operand_t right,
	output calc_pkg::display_t disp
);

	calc_pkg::result_t left_ext; // zero extended so the sign bit is clear
	calc_pkg::result_t right_ext;
	calc_pkg::result_t alu_out; // left +/- right
	calc_pkg::result_t answer; // frozen result
	logic ans_en_q; // ans_en one cycle back
	logic ans_load;

	//////////////////////////////
	// add / subtract
	//////////////////////////////

	assign left_ext = calc_pkg::result_t'({1'b0, left});
	assign right_ext = calc_pkg::result_t'({1'b0, right});

	// differences always fit in 17 bits
	// sums past 65535 land in the sign bit
	assign alu_out = ctrl.subtract ? (left_ext - right_ext) : (left_ext + right_ext);

	assign ans_load = ctrl.ans_en & ~ans_en_q; // rising edge only

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ans_en_q <= 1'b0;
			answer <= '0;
		end
		else
		begin
			ans_en_q <= ctrl.ans_en;
			if (ans_load)
				answer <= alu_out; // loaded once per calculation
		end
	end

	//////////////////////////////
	// display mux
	//////////////////////////////

	// right operand stays up for the one cycle before the answer lands
	always_comb
	begin
		if (ans_en_q)
			disp = '{value: answer, is_answer: 1'b1};
		else if (ctrl.right_en || ctrl.ans_en)
			disp = '{value: right_ext, is_answer: 1'b0};
		else
			disp = '{value: left_ext, is_answer: 1'b0};
	end

endmodule

//--- logic/calc_top.sv
module calc_top
(
	input logic clk,
	input logic rst_n,
	input logic add, // buttons active low
	input logic minus,
	input logic equal,
	input logic digit_valid, // keypad strobe
	input calc_pkg::digit_t digit,
	output calc_pkg::display_t disp,
	output calc_pkg::calc_state_e state
);

	calc_pkg::key_evt_t evt; // pulses from the key block
	calc_pkg::entry_ctrl_t ctrl; // enables from the fsm
	calc_pkg::operand_t left_value;
	calc_pkg::operand_t right_value;

	//////////////////////////////
	// input side
	//////////////////////////////

	calc_keys keys_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.add (add),
		.minus (minus),
		.equal (equal),
		.digit_valid (digit_valid),
		.digit (digit),
		.evt (evt)
	);

	calc_fsm fsm_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.evt (evt),
		.ctrl (ctrl),
		.state (state)
	);

	//////////////////////////////
	// operands, side by side
	//////////////////////////////

	operand_entry left_entry_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.enable (ctrl.left_en),
		.digit_valid (evt.digit_valid),
		.digit (evt.digit),
		.value (left_value)
	);

	operand_entry right_entry_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.enable (ctrl.right_en),
		.digit_valid (evt.digit_valid),
		.digit (evt.digit),
		.value (right_value)
	);

	// answer and display select
	calc_result result_inst
	(
		.clk (clk),
		.rst_n (rst_n),
		.ctrl (ctrl),
		.left (left_value),
		.right (right_value),
		.disp (disp)
	);

endmodule

//--- logic/operand_entry.sv
module operand_entry
(
	input logic clk,
	input logic rst_n,
	input logic enable, // this operand is being keyed
	input logic digit_valid, // one-cycle pulse, code already filtered
	input calc_pkg::digit_t digit,
	output calc_pkg::operand_t value
);

	calc_pkg::operand_t times_ten; // value * 10, wrapped
	calc_pkg::operand_t next_value;

	//////////////////////////////
	// decimal shift
	//////////////////////////////

	// x*10 = x*8 + x*2, carries past the top bit are dropped
	always_comb
	begin
		times_ten = (value << 3) + (value << 1);
		next_value = times_ten + calc_pkg::operand_t'(digit); // zero extend digit
	end

	//////////////////////////////
	// operand register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			value <= '0;
		else if (enable && digit_valid)
			value <= next_value;
		// otherwise hold, also while the other operand is keyed
	end

endmodule
